// ==== tiny_gpu.f ====
+incdir+rtl
rtl/gpu_pkg.sv
rtl/dispatch.sv
rtl/mem_controller.sv
rtl/core.sv
rtl/gpu.sv
testbench/clock_gen.sv
testbench/ext_mem.sv
testbench/gpu_tb.sv

// ==== Makefile ====
TOP = gpu_tb

all: run

obj_dir/V$(TOP): tiny_gpu.f rtl/*.sv rtl/*.svh testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f tiny_gpu.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Everything OK" run.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tiny_gpu.f

clean:
	rm -rf obj_dir run.log

.PHONY: all run lint clean

// ==== testbench/gpu_tb.sv ====
// Testbench for the compute unit with vector add and vector multiply kernels and protocol checks
`include "gpu_settings.svh"

module gpu_tb
    import gpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PCH = `GPU_PROG_CHANNELS;
    localparam int DCH = `GPU_DATA_CHANNELS;
    // Each kernel needs well under 1000 cycles at 4-cycle memory latency
    localparam int WATCHDOG_NS = 200000;
    // Vector layout in data memory
    localparam int B_BASE = 32;
    localparam int C_BASE = 64;
    localparam int VEC_LEN = 32;

    logic clk;
    logic rst_n;
    logic start;
    logic done;
    logic dcr_write;
    thread_count_t dcr_data;
    prog_req_t prog_mem_req [PCH];
    prog_rsp_t prog_mem_rsp [PCH];
    data_req_t data_mem_req [DCH];
    data_rsp_t data_mem_rsp [DCH];

    // Flat views for the behavioural memories
    logic pm_valid [PCH];
    logic pm_write [PCH];
    prog_addr_t pm_addr [PCH];
    instr_t pm_wdata [PCH];
    logic pm_ready [PCH];
    instr_t pm_rdata [PCH];
    logic dm_valid [DCH];
    logic dm_write [DCH];
    data_addr_t dm_addr [DCH];
    data_word_t dm_wdata [DCH];
    logic dm_ready [DCH];
    data_word_t dm_rdata [DCH];

    data_word_t a_vals [VEC_LEN];
    data_word_t b_vals [VEC_LEN];
    logic started;
    logic any_data_req;
    logic any_prog_req;
    int checks;
    int data_errors;
    int protocol_errors;

    clock_gen u_clock (
        .clk(clk),
        .rst_n(rst_n)
    );

    gpu UUT (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .done(done),
        .dcr_write(dcr_write),
        .dcr_data(dcr_data),
        .prog_mem_req(prog_mem_req),
        .prog_mem_rsp(prog_mem_rsp),
        .data_mem_req(data_mem_req),
        .data_mem_rsp(data_mem_rsp)
    );

    ext_mem #(
        .CHANNELS(PCH),
        .ADDR_BITS(`GPU_PROG_ADDR_BITS),
        .DATA_BITS(`GPU_PROG_DATA_BITS)
    ) prog_mem (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(pm_valid),
        .req_write(pm_write),
        .req_addr(pm_addr),
        .req_wdata(pm_wdata),
        .rsp_ready(pm_ready),
        .rsp_rdata(pm_rdata)
    );

    ext_mem #(
        .CHANNELS(DCH),
        .ADDR_BITS(`GPU_DATA_ADDR_BITS),
        .DATA_BITS(`GPU_DATA_BITS)
    ) data_mem (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(dm_valid),
        .req_write(dm_write),
        .req_addr(dm_addr),
        .req_wdata(dm_wdata),
        .rsp_ready(dm_ready),
        .rsp_rdata(dm_rdata)
    );

    for (genvar p = 0; p < PCH; p++) begin : g_prog_map
        assign pm_valid[p] = prog_mem_req[p].valid;
        assign pm_write[p] = 1'b0;
        assign pm_addr[p] = prog_mem_req[p].addr;
        assign pm_wdata[p] = '0;
        assign prog_mem_rsp[p] = '{ready: pm_ready[p], rdata: pm_rdata[p]};

        // Fetch fields frozen until ready
        assert property (@(posedge clk) disable iff (!rst_n)
            prog_mem_req[p].valid && !prog_mem_rsp[p].ready |=> $stable(prog_mem_req[p]))
        else begin
            $display("Program channel %0d request changed or dropped before ready", p);
            protocol_errors++;
        end

        // Program controller is read-only
        assert property (@(posedge clk) disable iff (!rst_n)
            !(UUT.prog_chan_req[p].valid && UUT.prog_chan_req[p].write))
        else begin
            $display("Program channel %0d issued a write", p);
            protocol_errors++;
        end
    end

    for (genvar c = 0; c < DCH; c++) begin : g_data_map
        assign dm_valid[c] = data_mem_req[c].valid;
        assign dm_write[c] = data_mem_req[c].write;
        assign dm_addr[c] = data_mem_req[c].addr;
        assign dm_wdata[c] = data_mem_req[c].wdata;
        assign data_mem_rsp[c] = '{ready: dm_ready[c], rdata: dm_rdata[c]};

        assert property (@(posedge clk) disable iff (!rst_n)
            data_mem_req[c].valid && !data_mem_rsp[c].ready |=> $stable(data_mem_req[c]))
        else begin
            $display("Data channel %0d request changed or dropped before ready", c);
            protocol_errors++;
        end
    end

    always_comb begin
        any_data_req = 1'b0;
        any_prog_req = 1'b0;
        for (int c = 0; c < DCH; c++) begin
            any_data_req |= data_mem_req[c].valid;
        end
        for (int p = 0; p < PCH; p++) begin
            any_prog_req |= prog_mem_req[p].valid;
        end
    end

    // Memory stays quiet until the first start
    assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !(any_data_req || any_prog_req))
    else begin
        $display("Memory request seen before the first start");
        protocol_errors++;
    end

    // No data traffic once the kernel reports done
    assert property (@(posedge clk) disable iff (!rst_n) done |-> !any_data_req)
    else begin
        $display("Data request seen while done was high");
        protocol_errors++;
    end

    // Done holds until the next start
    assert property (@(posedge clk) disable iff (!rst_n) done && !start |=> done)
    else begin
        $display("Done dropped without a start");
        protocol_errors++;
    end

    function automatic instr_t encode(input opcode_t op, input reg_idx_t rd,
                                      input reg_idx_t rs, input reg_idx_t rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic instr_t encode_const(input reg_idx_t rd, input data_word_t imm);
        return {CONST, rd, 1'b0, imm};
    endfunction

    // Untouched data rows, unique per address
    function automatic data_word_t marker(input int addr);
        return data_word_t'(addr) ^ 8'h5A;
    endfunction

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else begin
            $display("MISMATCH %s %s expected %0d actual %0d", name, what, expected, actual);
            data_errors++;
        end
    endtask

    // Element-wise kernel, combine is ADD or MUL
    task automatic load_kernel(input opcode_t combine);
        instr_t prog [11];
        prog = '{
            encode(MUL, 0, 5, 6),
            encode(ADD, 0, 0, 7),
            encode_const(1, 8'(B_BASE)),
            encode(ADD, 1, 1, 0),
            encode_const(2, 8'(C_BASE)),
            encode(ADD, 2, 2, 0),
            encode(LDR, 3, 0, 0),
            encode(LDR, 4, 1, 0),
            encode(combine, 3, 3, 4),
            encode(STR, 0, 2, 3),
            encode(RET, 0, 0, 0)
        };
        // Unused rows hold RET tagged with their address
        for (int a = 0; a < 2**`GPU_PROG_ADDR_BITS; a++) begin
            prog_mem.mem[a] = instr_t'({RET, 4'h0, 8'(a)});
        end
        foreach (prog[i]) begin
            prog_mem.mem[i] = prog[i];
        end
    endtask

    task automatic load_data(input int salt);
        for (int a = 0; a < 2**`GPU_DATA_ADDR_BITS; a++) begin
            data_mem.mem[a] = marker(a);
        end
        for (int i = 0; i < VEC_LEN; i++) begin
            a_vals[i] = data_word_t'(i * 37 + salt);
            b_vals[i] = data_word_t'(i * 91 + 3 * salt + 200);
            data_mem.mem[i] = a_vals[i];
            data_mem.mem[B_BASE + i] = b_vals[i];
        end
    endtask

    task automatic check_results(input string name, input int threads, input opcode_t combine);
        data_word_t expected;
        for (int i = 0; i < VEC_LEN; i++) begin
            if (i >= threads) begin
                expected = marker(C_BASE + i);
            end else if (combine == MUL) begin
                expected = data_word_t'(a_vals[i] * b_vals[i]);
            end else begin
                expected = data_word_t'(a_vals[i] + b_vals[i]);
            end
            check_value(name, $sformatf("c[%0d]", i), expected, data_mem.mem[C_BASE + i]);
        end
    endtask

    task automatic check_reset_state();
        check_value("reset", "done", 0, done);
        for (int p = 0; p < PCH; p++) begin
            check_value("reset", $sformatf("prog valid %0d", p), 0, prog_mem_req[p].valid);
        end
        for (int c = 0; c < DCH; c++) begin
            check_value("reset", $sformatf("data valid %0d", c), 0, data_mem_req[c].valid);
        end
    endtask

    task automatic run_kernel(input string name, input thread_count_t threads,
                              input opcode_t combine, input int salt);
        load_kernel(combine);
        load_data(salt);
        @(posedge clk);
        dcr_write <= 1'b1;
        dcr_data <= threads;
        @(posedge clk);
        dcr_write <= 1'b0;
        start <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Old done has cleared by now, watchdog bounds the wait
        do begin
            @(negedge clk);
        end while (!done);
        check_results(name, threads, combine);
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        start = 1'b0;
        dcr_write = 1'b0;
        dcr_data = '0;
        started = 1'b0;
        checks = 0;
        data_errors = 0;
        protocol_errors = 0;
        wait (rst_n);
        @(negedge clk);
        check_reset_state();
        // Two full blocks
        run_kernel("vector_add", 8'd8, ADD, 0);
        // Third block has only two lanes
        run_kernel("vector_mul", 8'd10, MUL, 17);
        // Let late protocol violations surface
        repeat (4) @(posedge clk);
        $display("Checks: %0d, data mismatches: %0d, protocol errors: %0d",
                 checks, data_errors, protocol_errors);
        if (data_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== testbench/ext_mem.sv ====
// Behavioural multi-channel memory with random response latency and a directly loaded array
module ext_mem #(
    parameter int CHANNELS = 1,
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid [CHANNELS],
    input  logic req_write [CHANNELS],
    input  logic [ADDR_BITS-1:0] req_addr [CHANNELS],
    input  logic [DATA_BITS-1:0] req_wdata [CHANNELS],
    output logic rsp_ready [CHANNELS],
    output logic [DATA_BITS-1:0] rsp_rdata [CHANNELS]
);
    timeunit 1ns;
    timeprecision 1ps;

    // Loaded by the testbench while the GPU is idle
    logic [DATA_BITS-1:0] mem [2**ADDR_BITS];
    // Cycles left before the channel answers
    logic [2:0] wait_left [CHANNELS];
    logic busy [CHANNELS];
    logic [15:0] lfsr;

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    always @(posedge clk) begin
        logic [1:0] extra;
        if (!rst_n) begin
            lfsr = 16'd53307;
            for (int c = 0; c < CHANNELS; c++) begin
                busy[c] <= 1'b0;
                rsp_ready[c] <= 1'b0;
            end
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                // Ready is a single pulse
                rsp_ready[c] <= 1'b0;
                if (busy[c]) begin
                    if (wait_left[c] == 3'd1) begin
                        rsp_ready[c] <= 1'b1;
                        rsp_rdata[c] <= mem[req_addr[c]];
                        if (req_write[c]) begin
                            mem[req_addr[c]] <= req_wdata[c];
                        end
                        busy[c] <= 1'b0;
                    end else begin
                        wait_left[c] <= wait_left[c] - 3'd1;
                    end
                end else if (req_valid[c] && !rsp_ready[c]) begin
                    // Two LFSR steps, one per latency bit, latency 1 to 4
                    lfsr = lfsr_next(lfsr);
                    extra[0] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    extra[1] = lfsr[0];
                    wait_left[c] <= 3'(extra) + 3'd1;
                    busy[c] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== testbench/clock_gen.sv ====
// Free-running 20 ns clock and a 3-cycle active-low reset
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== rtl/gpu.sv ====
// Top level with dispatcher, program and data memory controllers and the compute cores
`include "gpu_settings.svh"

module gpu
    import gpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done,
    input  logic dcr_write,
    input  thread_count_t dcr_data,
    output prog_req_t prog_mem_req [`GPU_PROG_CHANNELS],
    input  prog_rsp_t prog_mem_rsp [`GPU_PROG_CHANNELS],
    output data_req_t data_mem_req [`GPU_DATA_CHANNELS],
    input  data_rsp_t data_mem_rsp [`GPU_DATA_CHANNELS]
);
    localparam int LANES = `GPU_THREADS_PER_BLOCK;
    localparam int NUM_LSUS = `GPU_NUM_CORES * LANES;

    logic [`GPU_NUM_CORES-1:0] core_start;
    logic [`GPU_NUM_CORES-1:0] core_reset;
    logic [`GPU_NUM_CORES-1:0] core_done;
    block_id_t core_block_id [`GPU_NUM_CORES];
    lane_count_t core_lane_count [`GPU_NUM_CORES];

    // Flattened consumer side, core c lane l is entry c*LANES+l
    data_req_t lsu_req [NUM_LSUS];
    data_rsp_t lsu_rsp [NUM_LSUS];
    // Fetch requests carried as data requests with write tied off
    data_req_t fetch_req [`GPU_NUM_CORES];
    prog_rsp_t fetch_rsp [`GPU_NUM_CORES];
    data_req_t prog_chan_req [`GPU_PROG_CHANNELS];

    dispatch u_dispatch (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .dcr_write(dcr_write),
        .dcr_data(dcr_data),
        .core_done(core_done),
        .core_start(core_start),
        .core_reset(core_reset),
        .block_id(core_block_id),
        .lane_count(core_lane_count),
        .done(done)
    );

    mem_controller #(.rsp_t(data_rsp_t)) u_data_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .consumer_req(lsu_req),
        .consumer_rsp(lsu_rsp),
        .mem_req(data_mem_req),
        .mem_rsp(data_mem_rsp)
    );

    mem_controller #(.rsp_t(prog_rsp_t)) u_prog_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .consumer_req(fetch_req),
        .consumer_rsp(fetch_rsp),
        .mem_req(prog_chan_req),
        .mem_rsp(prog_mem_rsp)
    );

    // Only valid and address reach program memory
    for (genvar p = 0; p < `GPU_PROG_CHANNELS; p++) begin : g_prog_ch
        assign prog_mem_req[p] = '{valid: prog_chan_req[p].valid, addr: prog_chan_req[p].addr};
    end

    for (genvar c = 0; c < `GPU_NUM_CORES; c++) begin : g_core
        prog_req_t core_prog_req;
        data_req_t core_data_req [LANES];
        data_rsp_t core_data_rsp [LANES];

        assign fetch_req[c] = '{valid: core_prog_req.valid, write: 1'b0,
                                addr: core_prog_req.addr, wdata: '0};

        for (genvar l = 0; l < LANES; l++) begin : g_lane
            assign lsu_req[c * LANES + l] = core_data_req[l];
            assign core_data_rsp[l] = lsu_rsp[c * LANES + l];
        end

        core u_core (
            .clk(clk),
            .rst_n(rst_n),
            .core_reset(core_reset[c]),
            .core_start(core_start[c]),
            .block_id(core_block_id[c]),
            .lane_count(core_lane_count[c]),
            .core_done(core_done[c]),
            .prog_req(core_prog_req),
            .prog_rsp(fetch_rsp[c]),
            .data_req(core_data_req),
            .data_rsp(core_data_rsp)
        );
    end

endmodule

// ==== rtl/core.sv ====
// Compute core with fetch, decode, per-lane register files, ALUs and load/store units
`include "gpu_settings.svh"

module core
    import gpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic core_reset,
    input  logic core_start,
    input  block_id_t block_id,
    input  lane_count_t lane_count,
    output logic core_done,
    output prog_req_t prog_req,
    input  prog_rsp_t prog_rsp,
    output data_req_t data_req [`GPU_THREADS_PER_BLOCK],
    input  data_rsp_t data_rsp [`GPU_THREADS_PER_BLOCK]
);
    localparam int LANES = `GPU_THREADS_PER_BLOCK;

    core_state_t state;
    prog_addr_t pc;
    instr_t instr;
    block_id_t blk;
    lane_count_t lanes;

    // r0..r4 are writable, r5..r7 are special
    data_word_t regs [LANES][5];
    data_word_t opa [LANES];
    data_word_t opb [LANES];
    data_word_t result [LANES];

    opcode_t op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    data_word_t imm;
    logic mem_op;
    logic writes_rd;
    logic pending;
    logic [LANES-1:0] active;

    // Field decode
    assign op = opcode_t'(instr[15:12]);
    assign rd = instr[11:9];
    assign rs = instr[8:6];
    assign rt = instr[5:3];
    assign imm = instr[7:0];
    assign mem_op = (op == LDR) || (op == STR);
    assign writes_rd = (op == ADD) || (op == SUB) || (op == MUL) || (op == CONST) || (op == LDR);

    always_comb begin
        pending = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            // Lanes past the block's thread count sit out
            active[l] = (l < lanes);
            pending |= data_req[l].valid;
        end
    end

    // Single fetcher, request held for the whole FETCH state
    assign prog_req.valid = (state == FETCH);
    assign prog_req.addr = pc;
    assign core_done = (state == DONE);

    // Block id, lanes per block and lane index in r5, r6, r7
    function automatic data_word_t read_reg(input int lane, input reg_idx_t idx);
        case (idx)
            3'd5: return data_word_t'(blk);
            3'd6: return data_word_t'(LANES);
            3'd7: return data_word_t'(lane);
            default: return regs[lane][idx];
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || core_reset) begin
            state <= IDLE;
            for (int l = 0; l < LANES; l++) begin
                data_req[l].valid <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (core_start) begin
                        blk <= block_id;
                        lanes <= lane_count;
                        pc <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (prog_rsp.ready) begin
                        instr <= prog_rsp.rdata;
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    // Register read for every lane
                    for (int l = 0; l < LANES; l++) begin
                        opa[l] <= read_reg(l, rs);
                        opb[l] <= read_reg(l, rt);
                    end
                    state <= REQUEST;
                end
                REQUEST: begin
                    // LDR rd, [rs] and STR [rs], rt
                    for (int l = 0; l < LANES; l++) begin
                        if (active[l] && mem_op) begin
                            data_req[l].valid <= 1'b1;
                            data_req[l].write <= (op == STR);
                            data_req[l].addr <= opa[l];
                            data_req[l].wdata <= opb[l];
                        end
                    end
                    state <= WAIT;
                end
                WAIT: begin
                    for (int l = 0; l < LANES; l++) begin
                        if (data_rsp[l].ready) begin
                            data_req[l].valid <= 1'b0;
                            result[l] <= data_rsp[l].rdata;
                        end
                    end
                    // Lock-step, so every lane must finish
                    if (!pending) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    for (int l = 0; l < LANES; l++) begin
                        case (op)
                            ADD: result[l] <= opa[l] + opb[l];
                            SUB: result[l] <= opa[l] - opb[l];
                            MUL: result[l] <= opa[l] * opb[l];
                            CONST: result[l] <= imm;
                            default: ;
                        endcase
                    end
                    state <= UPDATE;
                end
                UPDATE: begin
                    if (op == RET) begin
                        state <= DONE;
                    end else begin
                        pc <= pc + 1'b1;
                        state <= FETCH;
                    end
                end
                DONE: ;
                default: state <= IDLE;
            endcase
        end
    end

    // Write-back, special registers are never written
    always_ff @(posedge clk) begin
        if (state == UPDATE && writes_rd && rd < 3'd5) begin
            for (int l = 0; l < LANES; l++) begin
                if (active[l]) begin
                    regs[l][rd] <= result[l];
                end
            end
        end
    end

endmodule

// ==== rtl/mem_controller.sv ====
// Multi-channel memory request controller with per-channel claim state machines
`include "gpu_settings.svh"

module mem_controller
    import gpu_pkg::*;
#(
    // Response type, its rdata sets the returned word width
    parameter type rsp_t = data_rsp_t,
    localparam bit IS_PROG = ($bits(rsp_t) == $bits(prog_rsp_t)),
    localparam int NUM_CONSUMERS = IS_PROG ? `GPU_NUM_CORES
                                           : `GPU_NUM_CORES * `GPU_THREADS_PER_BLOCK,
    localparam int NUM_CHANNELS = IS_PROG ? `GPU_PROG_CHANNELS : `GPU_DATA_CHANNELS
) (
    input  logic clk,
    input  logic rst_n,
    input  data_req_t consumer_req [NUM_CONSUMERS],
    output rsp_t consumer_rsp [NUM_CONSUMERS],
    output data_req_t mem_req [NUM_CHANNELS],
    input  rsp_t mem_rsp [NUM_CHANNELS]
);
    localparam int IDX_BITS = $clog2(NUM_CONSUMERS);

    typedef enum logic [1:0] {
        IDLE, READ_WAIT, WRITE_WAIT, RELAY
    } chan_state_t;

    chan_state_t state [NUM_CHANNELS];
    // Consumer each channel is serving
    logic [IDX_BITS-1:0] owner [NUM_CHANNELS];
    // Consumers already owned by some channel
    logic [NUM_CONSUMERS-1:0] claimed;

    always_ff @(posedge clk) begin
        logic [NUM_CONSUMERS-1:0] taken;
        logic found;
        if (!rst_n) begin
            claimed <= '0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                state[c] <= IDLE;
                mem_req[c].valid <= 1'b0;
            end
            for (int i = 0; i < NUM_CONSUMERS; i++) begin
                consumer_rsp[i].ready <= 1'b0;
            end
        end else begin
            // Updated as channels claim, so two channels never pick the same consumer
            taken = claimed;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                case (state[c])
                    IDLE: begin
                        found = 1'b0;
                        // Lowest-numbered free requester wins
                        for (int i = 0; i < NUM_CONSUMERS; i++) begin
                            if (!found && consumer_req[i].valid && !taken[i]) begin
                                found = 1'b1;
                                taken[i] = 1'b1;
                                owner[c] <= IDX_BITS'(i);
                                mem_req[c] <= consumer_req[i];
                                state[c] <= consumer_req[i].write ? WRITE_WAIT : READ_WAIT;
                            end
                        end
                    end
                    READ_WAIT, WRITE_WAIT: begin
                        if (mem_rsp[c].ready) begin
                            mem_req[c].valid <= 1'b0;
                            consumer_rsp[owner[c]].ready <= 1'b1;
                            // Writes return no data
                            if (state[c] == READ_WAIT) begin
                                consumer_rsp[owner[c]].rdata <= mem_rsp[c].rdata;
                            end
                            state[c] <= RELAY;
                        end
                    end
                    RELAY: begin
                        consumer_rsp[owner[c]].ready <= 1'b0;
                        // Hold the claim until the consumer lets go of valid
                        if (!consumer_req[owner[c]].valid) begin
                            taken[owner[c]] = 1'b0;
                            state[c] <= IDLE;
                        end
                    end
                    default: state[c] <= IDLE;
                endcase
            end
            claimed <= taken;
        end
    end

endmodule

// ==== rtl/dispatch.sv ====
// Thread-count register, block dispatch to the cores and kernel completion
`include "gpu_settings.svh"

module dispatch
    import gpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic dcr_write,
    input  thread_count_t dcr_data,
    input  logic [`GPU_NUM_CORES-1:0] core_done,
    output logic [`GPU_NUM_CORES-1:0] core_start,
    output logic [`GPU_NUM_CORES-1:0] core_reset,
    output block_id_t block_id [`GPU_NUM_CORES],
    output lane_count_t lane_count [`GPU_NUM_CORES],
    output logic done
);
    localparam int LANES = `GPU_THREADS_PER_BLOCK;

    thread_count_t thread_count;
    block_id_t total_blocks;
    // Blocks handed out and blocks finished in the current kernel
    block_id_t dispatched;
    block_id_t completed;
    logic running;
    // Core holds a block that has not reported done yet
    logic [`GPU_NUM_CORES-1:0] busy;
    logic [8:0] padded;

    // Thread count rounded up to whole blocks
    always_comb begin
        padded = {1'b0, thread_count} + 9'(LANES - 1);
        total_blocks = block_id_t'(padded / LANES);
    end

    always_ff @(posedge clk) begin
        block_id_t next_blk;
        block_id_t finished;
        thread_count_t remaining;
        logic free;
        if (!rst_n) begin
            thread_count <= '0;
            running <= 1'b0;
            done <= 1'b0;
            busy <= '0;
            core_start <= '0;
            core_reset <= '0;
            dispatched <= '0;
            completed <= '0;
        end else begin
            // A new kernel restarts both counts
            next_blk = start ? '0 : dispatched;
            finished = start ? '0 : completed;
            // Start pulse always trails the reset pulse by one cycle
            core_start <= core_reset;
            core_reset <= '0;
            if (dcr_write) begin
                thread_count <= dcr_data;
            end
            if (start) begin
                running <= 1'b1;
                done <= 1'b0;
            end
            for (int c = 0; c < `GPU_NUM_CORES; c++) begin
                free = !busy[c];
                // core_done still shows the old block while its reset pulse is out
                if (busy[c] && core_done[c] && !core_reset[c]) begin
                    finished = finished + 1'b1;
                    free = 1'b1;
                end
                if ((start || running) && free && next_blk < total_blocks) begin
                    remaining = thread_count - thread_count_t'(next_blk * LANES);
                    core_reset[c] <= 1'b1;
                    busy[c] <= 1'b1;
                    block_id[c] <= next_blk;
                    // Last block may be partial
                    lane_count[c] <= (remaining < LANES) ? lane_count_t'(remaining)
                                                         : lane_count_t'(LANES);
                    next_blk = next_blk + 1'b1;
                end else if (free) begin
                    busy[c] <= 1'b0;
                end
            end
            dispatched <= next_blk;
            completed <= finished;
            if ((start || running) && finished == total_blocks) begin
                running <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/gpu_pkg.sv ====
// Width typedefs, memory request and response structs, opcode and core state enums
`include "gpu_settings.svh"

package gpu_pkg;

    // Plain vectors for the memory buses
    typedef logic [`GPU_DATA_ADDR_BITS-1:0] data_addr_t;
    typedef logic [`GPU_DATA_BITS-1:0] data_word_t;
    typedef logic [`GPU_PROG_ADDR_BITS-1:0] prog_addr_t;
    typedef logic [`GPU_PROG_DATA_BITS-1:0] instr_t;

    // Kernel and block bookkeeping
    typedef logic [7:0] thread_count_t;
    typedef logic [7:0] block_id_t;
    // One extra bit so a full block fits
    typedef logic [$clog2(`GPU_THREADS_PER_BLOCK):0] lane_count_t;
    typedef logic [2:0] reg_idx_t;

    // Data memory request, held steady until ready is seen
    typedef struct packed {
        logic valid;
        logic write;
        data_addr_t addr;
        data_word_t wdata;
    } data_req_t;

    // Ready is a single-cycle pulse, rdata valid with it on reads
    typedef struct packed {
        logic ready;
        data_word_t rdata;
    } data_rsp_t;

    // Program memory is read-only
    typedef struct packed {
        logic valid;
        prog_addr_t addr;
    } prog_req_t;

    typedef struct packed {
        logic ready;
        instr_t rdata;
    } prog_rsp_t;

    // Opcode sits in bits 15..12
    typedef enum logic [3:0] {
        NOP   = 4'b0000,
        ADD   = 4'b0011,
        SUB   = 4'b0100,
        MUL   = 4'b0101,
        LDR   = 4'b0111,
        STR   = 4'b1000,
        CONST = 4'b1001,
        RET   = 4'b1111
    } opcode_t;

    // Block-wide core sequence
    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, REQUEST, WAIT, EXECUTE, UPDATE, DONE
    } core_state_t;

endpackage

// ==== rtl/gpu_settings.svh ====
// Memory widths, core count, lanes per block and memory channel counts
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// Data memory has 256 rows of 8-bit words
`define GPU_DATA_ADDR_BITS 8
`define GPU_DATA_BITS 8

// Program memory has 256 rows of 16-bit instructions
`define GPU_PROG_ADDR_BITS 8
`define GPU_PROG_DATA_BITS 16

// Compute resources
`define GPU_NUM_CORES 2
`define GPU_THREADS_PER_BLOCK 4

// Concurrent requests each memory accepts
`define GPU_DATA_CHANNELS 4
`define GPU_PROG_CHANNELS 1

`endif
